//--- Makefile
TOP = mlpEngineTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f mlpEngine.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f mlpEngine.f --top-module $(TOP) -o simv
	@out="$$(./obj_dir/simv)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- design/denseLayer.sv
`timescale 1ns/1ps

module denseLayer #(
	parameter int NumIn = 4,
	parameter int NumOut = 2,
	parameter nnPkg::word_t [0:NumOut-1][0:NumIn-1] WeightTable = '0,
	parameter nnPkg::word_t [0:NumOut-1] BiasTable = '0
) (
	input  logic clk,
	input  logic reset,
	input  nnPkg::word_t [NumIn-1:0] inVec,
	input  logic inValid,
	output nnPkg::word_t [NumOut-1:0] outVec,
	output logic outValid
);
	logic [NumOut-1:0] neuronValid;

	// One neuron per table row, all fed by the same input vector
	for (genvar n = 0; n < NumOut; n++)
	begin : gNeuron
		neuronNode #(
			.NumIn(NumIn),
			.Weights(WeightTable[n]),
			.Bias(BiasTable[n])
		) i_neuron (
			.clk(clk),
			.reset(reset),
			.inVec(inVec),
			.inValid(inValid),
			.act(outVec[n]),
			.actValid(neuronValid[n])
		);
	end

	assign outValid = neuronValid[0];

	assert property (@(posedge clk) disable iff (reset) neuronValid == {NumOut{outValid}})
		else $error("denseLayer: neuron valid bits disagree");

endmodule

//--- design/featureFifo.sv
`timescale 1ns/1ps

module featureFifo #(
	parameter int Depth = 4
) (
	input  logic clk,
	input  logic reset,
	input  nnPkg::featureVec_t featureIn,
	input  logic featureValid,
	input  logic pop,
	output nnPkg::featureVec_t head,
	output logic notEmpty,
	output logic featureCredit
);
	import nnPkg::*;

	localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

	featureVec_t mem [Depth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [$clog2(Depth+1)-1:0] count;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (featureValid)
				wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
			case ({featureValid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (featureValid)
			mem[wrPtr] <= featureIn;
	end

	assign head = mem[rdPtr];
	assign notEmpty = (count != '0);
	assign featureCredit = pop; // Each freed slot goes straight back upstream

	assert property (@(posedge clk) disable iff (reset) !(featureValid && count == Depth))
		else $error("featureFifo: push while full, upstream overran its credits");

endmodule

//--- design/inferenceScheduler.sv
`timescale 1ns/1ps

module inferenceScheduler #(
	parameter int OutDepth = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic notEmpty,
	input  logic [$clog2(OutDepth+1)-1:0] queueCount,
	input  logic resultPush,
	output logic pop
);
	localparam int CountWidth = $clog2(OutDepth + 1);

	logic [CountWidth-1:0] inFlight;
	logic [CountWidth:0] reserved;

	// Queue slots already taken plus slots promised to vectors inside the layers
	assign reserved = queueCount + inFlight;
	assign pop = notEmpty && (reserved < (CountWidth + 1)'(OutDepth));

	always_ff @(posedge clk)
	begin
		if (reset)
			inFlight <= '0;
		else
		begin
			case ({pop, resultPush})
				2'b10: inFlight <= inFlight + 1'b1;
				2'b01: inFlight <= inFlight - 1'b1;
				default: inFlight <= inFlight;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) reserved <= (CountWidth + 1)'(OutDepth))
		else $error("inferenceScheduler: more results reserved than queue slots");

endmodule

//--- design/mlpEngine.sv
`timescale 1ns/1ps

module mlpEngine #(
	parameter int InDepth = 4,
	parameter int OutDepth = 4
) (
	input  logic clk,
	input  logic reset,
	input  nnPkg::featureVec_t featureIn,
	input  logic featureValid,
	output logic featureCredit,
	output nnPkg::resultVec_t resultOut,
	output logic resultValid,
	input  logic resultCredit
);
	import nnPkg::*;

	featureVec_t head;
	logic notEmpty;
	logic pop;
	logic [$clog2(OutDepth+1)-1:0] queueCount;
	hiddenVec_t hidden;
	logic hiddenValid;
	resultVec_t result;
	logic resultPush;

	featureFifo #(.Depth(InDepth)) i_featureFifo (
		.clk(clk),
		.reset(reset),
		.featureIn(featureIn),
		.featureValid(featureValid),
		.pop(pop),
		.head(head),
		.notEmpty(notEmpty),
		.featureCredit(featureCredit)
	);

	inferenceScheduler #(.OutDepth(OutDepth)) i_inferenceScheduler (
		.clk(clk),
		.reset(reset),
		.notEmpty(notEmpty),
		.queueCount(queueCount),
		.resultPush(resultPush),
		.pop(pop)
	);

	denseLayer #(
		.NumIn(NumFeatures),
		.NumOut(NumHidden),
		.WeightTable(HiddenWeights),
		.BiasTable(HiddenBias)
	) i_hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inVec(head.words),
		.inValid(pop), // Launch
		.outVec(hidden.words),
		.outValid(hiddenValid)
	);

	denseLayer #(
		.NumIn(NumHidden),
		.NumOut(NumOutputs),
		.WeightTable(OutputWeights),
		.BiasTable(OutputBias)
	) i_outputLayer (
		.clk(clk),
		.reset(reset),
		.inVec(hidden.words),
		.inValid(hiddenValid),
		.outVec(result.words),
		.outValid(resultPush)
	);

	resultQueue #(.Depth(OutDepth)) i_resultQueue (
		.clk(clk),
		.reset(reset),
		.resultIn(result),
		.resultPush(resultPush),
		.resultCredit(resultCredit),
		.queueCount(queueCount),
		.resultOut(resultOut),
		.resultValid(resultValid)
	);

endmodule

//--- design/neuronNode.sv
`timescale 1ns/1ps

module neuronNode #(
	parameter int NumIn = 4,
	parameter nnPkg::word_t [0:NumIn-1] Weights = '0,
	parameter nnPkg::word_t Bias = '0
) (
	input  logic clk,
	input  logic reset,
	input  nnPkg::word_t [NumIn-1:0] inVec,
	input  logic inValid,
	output nnPkg::word_t act,
	output logic actValid
);
	import nnPkg::*;

	word_t [NumIn-1:0] inReg;
	word_t sumReg;
	logic inStageValid;
	logic sumStageValid;
	logic signed [AccWidth-1:0] accSum;

	always_comb
	begin
		logic signed [2*DataWidth-1:0] product;
		accSum = AccWidth'(Bias);
		for (int i = 0; i < NumIn; i++)
		begin
			product = inReg[i] * Weights[i]; // Q16.16 product
			accSum = accSum + AccWidth'(product >>> FracBits); // Back to eight fraction bits
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inStageValid <= 1'b0;
			sumStageValid <= 1'b0;
			actValid <= 1'b0;
		end
		else
		begin
			inStageValid <= inValid;
			sumStageValid <= inStageValid;
			actValid <= sumStageValid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (inValid)
			inReg <= inVec;
		if (inStageValid)
			sumReg <= saturateWord(accSum);
		if (sumStageValid)
			act <= sumReg[DataWidth-1] ? '0 : sumReg; // Rectifier
	end

	assert property (@(posedge clk) disable iff (reset) !$isunknown(actValid))
		else $error("neuronNode: actValid is unknown after reset");

endmodule

//--- design/nnPkg.sv
package nnPkg;

	localparam int DataWidth = 16;
	localparam int FracBits = 8; // Q8.8 words
	localparam int AccWidth = 24;
	localparam int NumFeatures = 15;
	localparam int NumHidden = 4;
	localparam int NumOutputs = 2;

	typedef logic signed [DataWidth-1:0] word_t;

	// Word 0 sits in the least significant bits of each vector
	typedef struct packed {
		word_t [NumFeatures-1:0] words;
	} featureVec_t;

	typedef struct packed {
		word_t [NumHidden-1:0] words;
	} hiddenVec_t;

	typedef struct packed {
		word_t [NumOutputs-1:0] words;
	} resultVec_t;

	// Every weight stays below 2.0 in magnitude, so 15 products never wrap the accumulator
	localparam word_t [0:NumHidden-1][0:NumFeatures-1] HiddenWeights = '{
		'{16'sh00B9, 16'sh0040, 16'shFF80, 16'sh0012, 16'sh0100, 16'sh00DE, 16'shFFD4, 16'sh0180,
		  16'sh0033, 16'sh0116, 16'shFEF7, 16'shFE2C, 16'sh0186, 16'shFEC1, 16'sh017C},
		'{16'shFF20, 16'sh0150, 16'sh0022, 16'shFFE0, 16'sh0090, 16'shFF70, 16'sh0101, 16'sh0044,
		  16'shFFB0, 16'sh00C8, 16'sh0010, 16'shFF10, 16'sh0075, 16'sh0190, 16'shFFA0},
		'{16'shFE80, 16'shFF00, 16'shFFC0, 16'shFF90, 16'sh0020, 16'shFEE0, 16'shFF30, 16'shFFF0,
		  16'shFE40, 16'shFF60, 16'sh0030, 16'shFF50, 16'shFE90, 16'shFFA8, 16'shFF18},
		'{16'sh0066, 16'shFF9A, 16'sh0120, 16'sh0008, 16'shFF44, 16'sh00F0, 16'sh0058, 16'shFE70,
		  16'sh00A4, 16'sh0014, 16'sh01C0, 16'shFFCC, 16'sh0088, 16'shFF2C, 16'sh0036}
	};

	localparam word_t [0:NumHidden-1] HiddenBias = '{
		16'sh0020, 16'shFFC0, 16'sh0180, 16'sh0010
	};

	localparam word_t [0:NumOutputs-1][0:NumHidden-1] OutputWeights = '{
		'{16'sh0140, 16'shFF80, 16'sh00A0, 16'sh00C0},
		'{16'shFF60, 16'sh0110, 16'sh0080, 16'shFF90}
	};

	localparam word_t [0:NumOutputs-1] OutputBias = '{
		16'sh0040, 16'sh0100
	};

	localparam logic signed [AccWidth-1:0] AccMax = (2 ** (DataWidth - 1)) - 1;
	localparam logic signed [AccWidth-1:0] AccMin = -(2 ** (DataWidth - 1));

	function automatic word_t saturateWord(input logic signed [AccWidth-1:0] value);
		word_t clamped;
		if (value > AccMax)
			clamped = word_t'(AccMax);
		else if (value < AccMin)
			clamped = word_t'(AccMin);
		else
			clamped = word_t'(value);
		return clamped;
	endfunction

endpackage

//--- design/resultQueue.sv
`timescale 1ns/1ps

module resultQueue #(
	parameter int Depth = 4
) (
	input  logic clk,
	input  logic reset,
	input  nnPkg::resultVec_t resultIn,
	input  logic resultPush,
	input  logic resultCredit,
	output logic [$clog2(Depth+1)-1:0] queueCount,
	output nnPkg::resultVec_t resultOut,
	output logic resultValid
);
	import nnPkg::*;

	localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CreditWidth = 8; // Room for far more credits than downstream will grant

	resultVec_t mem [Depth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CreditWidth-1:0] credits;
	logic send;

	// A result arriving at an empty queue may leave in the same cycle
	assign send = (credits != '0) && ((queueCount != '0) || resultPush);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			queueCount <= '0;
			credits <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			resultValid <= send;
			if (resultPush)
				wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
			if (send)
				rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
			case ({resultPush, send})
				2'b10: queueCount <= queueCount + 1'b1;
				2'b01: queueCount <= queueCount - 1'b1;
				default: queueCount <= queueCount;
			endcase
			case ({resultCredit, send})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (resultPush)
			mem[wrPtr] <= resultIn;
		if (send)
			resultOut <= (queueCount == '0) ? resultIn : mem[rdPtr]; // Bypass when empty
	end

	assert property (@(posedge clk) disable iff (reset) !(resultPush && queueCount == Depth))
		else $error("resultQueue: push while full");

endmodule

//--- mlpEngine.f
+incdir+verif
design/nnPkg.sv
design/neuronNode.sv
design/denseLayer.sv
design/featureFifo.sv
design/inferenceScheduler.sv
design/resultQueue.sv
design/mlpEngine.sv
verif/mlpEngineTb.sv

//--- verif/mlpModel.svh
`ifndef MLP_MODEL_SVH
`define MLP_MODEL_SVH

// Q8.8 times Q8.8 gives sixteen fraction bits, so drop eight of them
function automatic longint scaledProduct(input word_t x, input word_t w);
	longint product;
	product = longint'(x) * longint'(w);
	return product >>> FracBits;
endfunction

function automatic word_t clampRelu(input longint sum);
	longint limited;
	if (sum > 32767)
		limited = 32767;
	else if (sum < -32768)
		limited = -32768;
	else
		limited = sum;
	if (limited < 0)
		limited = 0; // Rectifier after the clamp
	return word_t'(limited);
endfunction

function automatic hiddenVec_t hiddenModel(input featureVec_t fv);
	hiddenVec_t hv;
	longint sum;
	for (int n = 0; n < NumHidden; n++)
	begin
		sum = longint'(HiddenBias[n]);
		for (int i = 0; i < NumFeatures; i++)
			sum += scaledProduct(fv.words[i], HiddenWeights[n][i]);
		hv.words[n] = clampRelu(sum);
	end
	return hv;
endfunction

function automatic resultVec_t modelResult(input featureVec_t fv);
	hiddenVec_t hv;
	resultVec_t rv;
	longint sum;
	hv = hiddenModel(fv);
	for (int n = 0; n < NumOutputs; n++)
	begin
		sum = longint'(OutputBias[n]);
		for (int i = 0; i < NumHidden; i++)
			sum += scaledProduct(hv.words[i], OutputWeights[n][i]);
		rv.words[n] = clampRelu(sum);
	end
	return rv;
endfunction

`endif

//--- verif/mlpEngineTb.sv
`timescale 1ns/1ps

module mlpEngineTb;
	import nnPkg::*;

	localparam int InDepth = 4;
	localparam int OutDepth = 4;
	localparam int NumRows = 20;
	localparam int CycleLimit = 40 * NumRows + 200;

	typedef struct packed {
		featureVec_t features;
		logic [7:0] gap; // Idle cycles before the vector goes out
		logic [7:0] grant; // Downstream credits released after it is sent
		logic [7:0] delay; // Cycles held back before those credits go out
	} stimRow_t;

	logic clk;
	logic reset;
	featureVec_t featureIn;
	logic featureValid;
	logic featureCredit;
	resultVec_t resultOut;
	logic resultValid;
	logic resultCredit;

	stimRow_t rows [NumRows];
	resultVec_t expectedTable [NumRows];
	resultVec_t expected [$];
	int grantQueue [$];
	int seed = 39;
	int upCredits = InDepth;
	int popsSeen = 0;
	int grantsSeen = 0;
	int resultsSeen = 0;
	int cycleCount = 0;
	logic stimStarted = 1'b0;

	`include "mlpModel.svh"

	mlpEngine #(.InDepth(InDepth), .OutDepth(OutDepth)) i_mlpEngine (
		.clk(clk),
		.reset(reset),
		.featureIn(featureIn),
		.featureValid(featureValid),
		.featureCredit(featureCredit),
		.resultOut(resultOut),
		.resultValid(resultValid),
		.resultCredit(resultCredit)
	);

	task automatic stopOnFailure(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] want);
		if (actual !== want)
			stopOnFailure($sformatf("Error at time %0t: %s is %h, expected %h",
				$time, name, actual, want));
	endtask

	function automatic featureVec_t rampVec(input word_t start, input word_t step);
		featureVec_t fv;
		for (int i = 0; i < NumFeatures; i++)
			fv.words[i] = word_t'(start + step * i);
		return fv;
	endfunction

	task automatic setRow(input int r, input featureVec_t fv, input int gap, input int grant,
		input int delay);
		rows[r].features = fv;
		rows[r].gap = 8'(gap);
		rows[r].grant = 8'(grant);
		rows[r].delay = 8'(delay);
	endtask

	task automatic buildTable();
		featureVec_t fv;
		setRow(0, rampVec(16'sh0000, 16'sh0000), 5, 1, 0); // Bias alone reaches the outputs
		setRow(1, rampVec(16'sh0100, 16'sh0000), 2, 1, 0);
		setRow(2, rampVec(-16'sh0080, 16'sh0020), 2, 1, 0);
		setRow(3, rampVec(16'sh0200, -16'sh0030), 2, 1, 0);
		setRow(4, rampVec(16'sh0300, 16'sh0000), 2, 1, 0); // Hidden neuron 2 goes negative
		setRow(5, rampVec(16'sh7FFF, 16'sh0000), 2, 1, 0); // Hidden sums clamp at the maximum
		setRow(6, rampVec(16'sh8000, 16'sh0000), 2, 1, 0);
		setRow(7, rampVec(16'sh7000, -16'sh0F00), 2, 1, 0);
		for (int k = 0; k < InDepth; k++)
			setRow(8 + k, rampVec(word_t'(16'sh0080 + 16'sh0040 * k), word_t'(16'sh0008 * k)),
				(k == 0) ? 20 : 0, 1, 0);
		// Random rows run back to back with credits held until the last one is sent
		for (int k = 12; k < NumRows; k++)
		begin
			for (int i = 0; i < NumFeatures; i++)
				fv.words[i] = word_t'($random(seed));
			setRow(k, fv, (k == 12) ? 20 : 0, (k == NumRows - 1) ? NumRows - 12 : 0,
				(k == NumRows - 1) ? 40 : 0);
		end
		for (int k = 0; k < NumRows; k++)
			expectedTable[k] = modelResult(rows[k].features);
	endtask

	// Starts and ends 2 ns after a rising edge
	task automatic sendRow(input int r);
		repeat (rows[r].gap)
		begin
			@(posedge clk);
			#2;
		end
		while (upCredits == 0)
		begin
			@(posedge clk);
			#2;
		end
		featureIn = rows[r].features;
		featureValid = 1'b1;
		stimStarted = 1'b1;
		upCredits--;
		expected.push_back(expectedTable[r]);
		grantQueue.push_back(r);
		@(posedge clk);
		#2;
		featureValid = 1'b0;
	endtask

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		featureIn = '0;
		featureValid = 1'b0;
		resultCredit = 1'b0;
		buildTable();
		repeat (2) @(posedge clk);
		#2 reset = 1'b0;
		for (int r = 0; r < NumRows; r++)
			sendRow(r);
		while (resultsSeen < NumRows)
			@(posedge clk);
		repeat (10) @(posedge clk);
		// Every vector has left the fifo by now, so all upstream credits are back
		if (upCredits == InDepth)
		begin
			$display("All tests passed!");
			$finish;
		end
		else
			checkValue("upCredits", upCredits, InDepth);
	end

	initial
	begin : creditDriver
		int r;
		forever
		begin
			@(posedge clk);
			#1;
			if (grantQueue.size() != 0)
			begin
				r = grantQueue.pop_front();
				repeat (rows[r].delay) @(posedge clk);
				for (int i = 0; i < rows[r].grant; i++)
				begin
					@(posedge clk);
					#2 resultCredit = 1'b1;
				end
				@(posedge clk);
				#2 resultCredit = 1'b0;
			end
		end
	end

	always @(negedge clk)
	begin : monitor
		resultVec_t want;
		if (!reset)
		begin
			if (!stimStarted)
			begin
				checkValue("resultValid", resultValid, 1'b0);
				checkValue("featureCredit", featureCredit, 1'b0);
			end
			if (featureCredit)
			begin
				upCredits++;
				popsSeen++;
				if (upCredits > InDepth)
					stopOnFailure("The engine returned more upstream credits than were spent");
			end
			if (resultValid)
			begin
				if (grantsSeen <= resultsSeen)
					stopOnFailure("resultValid appeared without a downstream credit");
				else
				begin
					want = expected.pop_front();
					for (int w = 0; w < NumOutputs; w++)
						checkValue($sformatf("resultOut.words[%0d]", w), resultOut.words[w],
							want.words[w]);
					resultsSeen++;
				end
			end
			if (resultCredit)
				grantsSeen++;
			if (popsSeen > grantsSeen + OutDepth)
				stopOnFailure("featureCredit kept returning while downstream credits were withheld");
		end
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > CycleLimit)
			stopOnFailure($sformatf("Timeout: results still missing after %0d cycles", CycleLimit));
	end

endmodule
